/* dv/ahb_bus_testdata.txt */
# per path: addr trans wr s_rdy s_resp s_rdata exp_hsel exp_rdy exp_resp exp_rdata (hex)
# path order inst data peri, one line per clock cycle after reset
00000000 0 0 1 0 0011 1 1 0 0011 20000000 0 0 1 0 0021 1 1 0 0021 40000000 0 0 1 0 0031 1 1 0 0031
00000010 2 1 1 0 0012 1 1 0 0012 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 0 0000
00000014 2 0 1 0 0000 1 1 0 0000 20000040 2 1 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 0 0000
00000000 0 0 1 0 1234 1 1 0 1234 20000044 2 0 1 0 0000 1 1 0 0000 40000100 2 1 1 0 0000 1 1 0 0000
00000020 2 0 1 0 0000 1 1 0 0000 20000000 0 0 1 0 2244 1 1 0 2244 40000104 2 0 1 0 0000 1 1 0 0000
00000000 0 0 0 0 0000 1 0 0 0000 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 4104 1 1 0 4104
00000000 0 0 0 0 0000 1 0 0 0000 20000000 0 0 1 0 0000 1 1 0 0000 50000000 2 0 1 0 0000 0 1 0 0000
00000000 0 0 1 0 abcd 1 1 0 abcd 20000000 0 0 1 0 0000 1 1 0 0000 50000004 2 0 1 0 0000 0 0 1 0000
10000000 2 0 1 0 0000 0 1 0 0000 20000000 0 0 1 0 0000 1 1 0 0000 50000004 2 0 1 0 0000 0 1 1 0000
00000030 2 0 1 0 7777 1 0 1 0000 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 0 1 0000
00000030 2 0 1 0 7777 1 1 1 0000 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 1 0000
00000000 0 0 1 0 5555 1 1 0 5555 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 0 0000
10000000 0 0 1 0 0000 0 1 0 0000 30000000 0 0 1 0 0000 0 1 0 0000 40001000 1 0 1 0 0000 0 1 0 0000
10000000 1 0 1 0 0000 0 1 0 0000 30000000 1 0 1 0 0000 0 1 0 0000 40001000 0 0 1 0 0000 0 1 0 0000
00000000 0 0 1 0 0000 1 1 0 0000 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 0 0000
10000004 2 0 1 0 0000 0 1 0 0000 20000080 2 0 1 0 0000 1 1 0 0000 40000200 2 1 1 0 0000 1 1 0 0000
00000000 0 0 1 0 0000 1 0 1 0000 20000000 0 0 0 0 0000 1 0 0 0000 40000204 2 0 1 0 0000 1 1 0 0000
00000000 0 0 1 0 0000 1 1 1 0000 20000000 0 0 0 0 0000 1 0 0 0000 40000000 0 0 1 0 0204 1 1 0 0204
00000000 0 0 1 0 0000 1 1 0 0000 20000000 0 0 1 0 8080 1 1 0 8080 40000000 0 0 1 0 0000 1 1 0 0000
00000000 0 0 1 0 0000 1 1 0 0000 20000000 0 0 1 0 0000 1 1 0 0000 40000000 0 0 1 0 0000 1 1 0 0000

/* build.f */
verilog/ahb_pkg.sv
verilog/ahb_addr_decoder.sv
verilog/ahb_default_slave.sv
verilog/ahb_path.sv
verilog/ahb_bus.sv
dv/ahb_bus_checker.sv
dv/ahb_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator and run; the result comes from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module ahb_bus_tb \
	--Mdir obj_dir -o ahb_bus_sim || { echo "compile failed"; exit 1; }
out=$(./obj_dir/ahb_bus_sim)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1

/* dv/ahb_bus_tb.sv */
// testbench top for the AHB-Lite interconnect, replays the cycle table in dv/ against the DUT
`timescale 1ns/1ps

module ahb_bus_tb;

	import ahb_pkg::*;

	logic        hclk;
	logic        arst_n;
	// index 0 inst, 1 data, 2 peri
	mas_send_t   m_in [3];
	slv_send_t   m_out [3];
	slv_send_t   s_in [3];
	mas_send_t   s_out [3];
	logic        hsel [3];
	logic        exp_hsel [3];
	mas_send_t   exp_s_out [3];
	slv_send_t   exp_m_out [3];
	int          chk_errors [3];
	logic [31:0] f [30];
	string       line;
	int          fd;
	int          n_fields;
	int          n_lines = 0;
	int          line_no = 0;
	int          file_errors = 0;
	int          total_errors;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	// ======================================================================
	// clock, DUT, checkers
	// ======================================================================

	initial hclk = 1'b0;
	always #2 hclk = ~hclk;

	ahb_bus u_dut (
		.hclk            (hclk),
		.arst_n          (arst_n),
		.master_inst_in  (m_in[0]),
		.master_inst_out (m_out[0]),
		.slave_inst_in   (s_in[0]),
		.slave_inst_out  (s_out[0]),
		.hsel_slave_inst (hsel[0]),
		.master_data_in  (m_in[1]),
		.master_data_out (m_out[1]),
		.slave_data_in   (s_in[1]),
		.slave_data_out  (s_out[1]),
		.hsel_slave_data (hsel[1]),
		.master_peri_in  (m_in[2]),
		.master_peri_out (m_out[2]),
		.slave_peri_in   (s_in[2]),
		.slave_peri_out  (s_out[2]),
		.hsel_slave_peri (hsel[2])
	);

	ahb_bus_checker #(.path_name("inst")) u_chk_inst (
		hclk, hsel[0], s_out[0], m_out[0], exp_hsel[0], exp_s_out[0], exp_m_out[0],
		chk_errors[0]);
	ahb_bus_checker #(.path_name("data")) u_chk_data (
		hclk, hsel[1], s_out[1], m_out[1], exp_hsel[1], exp_s_out[1], exp_m_out[1],
		chk_errors[1]);
	ahb_bus_checker #(.path_name("peri")) u_chk_peri (
		hclk, hsel[2], s_out[2], m_out[2], exp_hsel[2], exp_s_out[2], exp_m_out[2],
		chk_errors[2]);

	// ======================================================================
	// stimulus helpers
	// ======================================================================

	// header and blank lines carry no cycle
	function automatic bit is_data_line(input string s);
		return (s.len() > 1) && (s.getc(0) != "#");
	endfunction

	// master and slave drive plus expected outputs for one path
	task automatic drive_path(input int p, input logic [31:0] addr, trans, wr,
		s_rdy, s_resp, s_rdata, e_hsel, e_rdy, e_resp, e_rdata);
		m_in[p].haddr  = addr;
		m_in[p].htrans = htrans_e'(trans[1:0]);
		m_in[p].hwrite = wr[0];
		m_in[p].hsize  = 3'b010;
		m_in[p].hburst = 3'b000;
		m_in[p].hprot  = 4'b0011;
		m_in[p].hwdata = ~addr;
		// master's own copy must never reach the slave
		m_in[p].hready = 1'b0;
		s_in[p].hreadyout = s_rdy[0];
		s_in[p].hresp     = hresp_e'(s_resp[0]);
		s_in[p].hrdata    = s_rdata;
		exp_hsel[p] = e_hsel[0];
		// slave sees the master's fields with the returned ready
		exp_s_out[p]        = m_in[p];
		exp_s_out[p].hready = e_rdy[0];
		exp_m_out[p].hreadyout = e_rdy[0];
		exp_m_out[p].hresp     = hresp_e'(e_resp[0]);
		exp_m_out[p].hrdata    = e_rdata;
	endtask

	// unmapped IDLE everywhere, response must follow the slave
	task automatic drive_reset_values();
		for (int p = 0; p < 3; p++) begin
			drive_path(p, 32'hF000_0000, 0, 0, 1, 0, 32'h5A00 + 32'(p),
				0, 1, 0, 32'h5A00 + 32'(p));
		end
	endtask

	task automatic apply_line();
		for (int p = 0; p < 3; p++) begin
			drive_path(p, f[p*10], f[p*10+1], f[p*10+2], f[p*10+3], f[p*10+4],
				f[p*10+5], f[p*10+6], f[p*10+7], f[p*10+8], f[p*10+9]);
		end
	endtask

	// ======================================================================
	// run limit
	// ======================================================================

	always @(posedge hclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the data file was not finished", cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

	// ======================================================================
	// main sequence
	// ======================================================================

	initial begin
		arst_n = 1'b0;
		drive_reset_values();
		fd = $fopen("dv/ahb_bus_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the data file dv/ahb_bus_testdata.txt");
			$display("Test failures found");
			$finish;
		end else begin
			// first pass only counts cycles for the limit
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && is_data_line(line)) begin
					n_lines = n_lines + 1;
				end
			end
			$fclose(fd);
			cycle_limit = n_lines + 8 + 20;
			fd = $fopen("dv/ahb_bus_testdata.txt", "r");
			repeat (8) @(posedge hclk);
			#1 arst_n = 1'b1;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && is_data_line(line)) begin
					n_fields = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
						f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29]);
					@(posedge hclk);
					#1;
					if (n_fields != 30) begin
						$display("data line %0d has %0d fields instead of 30", line_no, n_fields);
						file_errors = file_errors + 1;
					end else begin
						apply_line();
					end
					line_no = line_no + 1;
				end
			end
			$fclose(fd);
			// let the checkers sample the last cycle
			@(posedge hclk);
			#1;
			total_errors = chk_errors[0] + chk_errors[1] + chk_errors[2] + file_errors;
			$display("%0d cycles, %0d errors: inst %0d data %0d peri %0d data file %0d",
				line_no, total_errors, chk_errors[0], chk_errors[1], chk_errors[2],
				file_errors);
			if (total_errors == 0) begin
				$display("All tests passed!");
			end else begin
				$display("Test failures found");
			end
			$finish;
		end
	end

endmodule

/* dv/ahb_bus_checker.sv */
// per-path response checker, instantiated by ahb_bus_tb once for each of the three paths
`timescale 1ns/1ps

module ahb_bus_checker #(
	// label used in error lines
	parameter string path_name = "inst"
) (
	input  logic               hclk,
	// what the DUT shows on this path
	input  logic               act_hsel,
	input  ahb_pkg::mas_send_t act_slave_out,
	input  ahb_pkg::slv_send_t act_master_out,
	// what the testbench expects for the same cycle
	input  logic               exp_hsel,
	input  ahb_pkg::mas_send_t exp_slave_out,
	input  ahb_pkg::slv_send_t exp_master_out,
	output int                 err_count
);

	import ahb_pkg::*;

	initial err_count = 0;

	// one field, one line on mismatch
	task automatic compare_field(input string field, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("error at %0t: %s.%s expected %h actual %h",
				$time, path_name, field, exp_val, act_val);
			err_count = err_count + 1;
		end
	endtask

	// ======================================================================
	// sampling
	// ======================================================================

	// stimulus lands 1 ns after the edge, so sample late in the cycle
	// everything combinational has settled by then
	always @(posedge hclk) begin
		#3.5;
		compare_field("hsel_slave", 32'(exp_hsel), 32'(act_hsel));
		// address phase forwarded to the slave
		compare_field("slave_out.haddr", exp_slave_out.haddr, act_slave_out.haddr);
		compare_field("slave_out.htrans", 32'(exp_slave_out.htrans),
			32'(act_slave_out.htrans));
		compare_field("slave_out.hwrite", 32'(exp_slave_out.hwrite),
			32'(act_slave_out.hwrite));
		compare_field("slave_out.hsize", 32'(exp_slave_out.hsize), 32'(act_slave_out.hsize));
		compare_field("slave_out.hburst", 32'(exp_slave_out.hburst),
			32'(act_slave_out.hburst));
		compare_field("slave_out.hprot", 32'(exp_slave_out.hprot), 32'(act_slave_out.hprot));
		compare_field("slave_out.hwdata", exp_slave_out.hwdata, act_slave_out.hwdata);
		// returned ready as the slave sees it
		compare_field("slave_out.hready", 32'(exp_slave_out.hready),
			32'(act_slave_out.hready));
		// data phase response back to the master
		compare_field("master_out.hreadyout", 32'(exp_master_out.hreadyout),
			32'(act_master_out.hreadyout));
		compare_field("master_out.hresp", 32'(exp_master_out.hresp),
			32'(act_master_out.hresp));
		compare_field("master_out.hrdata", exp_master_out.hrdata, act_master_out.hrdata);
	end

endmodule

/* verilog/ahb_bus.sv */
// AHB-Lite interconnect top, three independent paths for inst, data and peripheral
`timescale 1ns/1ps

module ahb_bus #(
	// ======================================================================
	// address windows
	// ======================================================================
	// instruction memory, 64 KiB
	parameter ahb_pkg::haddr_t inst_base = 32'h0000_0000,
	parameter ahb_pkg::haddr_t inst_mask = 32'hFFFF_0000,
	// data memory, 64 KiB
	parameter ahb_pkg::haddr_t data_base = 32'h2000_0000,
	parameter ahb_pkg::haddr_t data_mask = 32'hFFFF_0000,
	// peripheral bridge, 4 KiB
	parameter ahb_pkg::haddr_t peri_base = 32'h4000_0000,
	parameter ahb_pkg::haddr_t peri_mask = 32'hFFFF_F000
) (
	input  logic               hclk,
	input  logic               arst_n,
	// instruction path
	input  ahb_pkg::mas_send_t master_inst_in,
	output ahb_pkg::slv_send_t master_inst_out,
	input  ahb_pkg::slv_send_t slave_inst_in,
	output ahb_pkg::mas_send_t slave_inst_out,
	output logic               hsel_slave_inst,
	// data path
	input  ahb_pkg::mas_send_t master_data_in,
	output ahb_pkg::slv_send_t master_data_out,
	input  ahb_pkg::slv_send_t slave_data_in,
	output ahb_pkg::mas_send_t slave_data_out,
	output logic               hsel_slave_data,
	// peripheral path
	input  ahb_pkg::mas_send_t master_peri_in,
	output ahb_pkg::slv_send_t master_peri_out,
	input  ahb_pkg::slv_send_t slave_peri_in,
	output ahb_pkg::mas_send_t slave_peri_out,
	output logic               hsel_slave_peri
);

	// ======================================================================
	// paths, no sharing between them
	// ======================================================================

	// instruction master to instruction memory
	ahb_path #(
		.region_base (inst_base),
		.region_mask (inst_mask)
	) u_path_inst (
		.hclk       (hclk),
		.arst_n     (arst_n),
		.master_in  (master_inst_in),
		.master_out (master_inst_out),
		.slave_in   (slave_inst_in),
		.slave_out  (slave_inst_out),
		.hsel_slave (hsel_slave_inst)
	);

	// data master to data memory
	ahb_path #(
		.region_base (data_base),
		.region_mask (data_mask)
	) u_path_data (
		.hclk       (hclk),
		.arst_n     (arst_n),
		.master_in  (master_data_in),
		.master_out (master_data_out),
		.slave_in   (slave_data_in),
		.slave_out  (slave_data_out),
		.hsel_slave (hsel_slave_data)
	);

	// peripheral master to peripheral bridge
	ahb_path #(
		.region_base (peri_base),
		.region_mask (peri_mask)
	) u_path_peri (
		.hclk       (hclk),
		.arst_n     (arst_n),
		.master_in  (master_peri_in),
		.master_out (master_peri_out),
		.slave_in   (slave_peri_in),
		.slave_out  (slave_peri_out),
		.hsel_slave (hsel_slave_peri)
	);

endmodule

/* verilog/ahb_path.sv */
// one fixed master-to-slave path with decoder, default slave and response mux
`timescale 1ns/1ps

module ahb_path #(
	// handed straight to the decoder
	parameter ahb_pkg::haddr_t region_base = 32'h0000_0000,
	parameter ahb_pkg::haddr_t region_mask = 32'hFFFF_0000
) (
	input  logic               hclk,
	input  logic               arst_n,
	// master side
	input  ahb_pkg::mas_send_t master_in,
	output ahb_pkg::slv_send_t master_out,
	// slave side
	input  ahb_pkg::slv_send_t slave_in,
	output ahb_pkg::mas_send_t slave_out,
	output logic               hsel_slave
);

	import ahb_pkg::*;

	logic      default_sel;
	logic      resp_sel;
	logic      hready_ret;
	logic      ds_hreadyout;
	hresp_e    ds_hresp;
	slv_send_t ds_resp;

	// ======================================================================
	// decode and error responder
	// ======================================================================

	ahb_addr_decoder #(
		.region_base (region_base),
		.region_mask (region_mask)
	) u_decoder (
		.hclk        (hclk),
		.arst_n      (arst_n),
		.haddr       (master_in.haddr),
		.htrans      (master_in.htrans),
		.hready      (hready_ret),
		.hsel        (hsel_slave),
		.default_sel (default_sel),
		.resp_sel    (resp_sel)
	);

	ahb_default_slave u_default_slave (
		.hclk        (hclk),
		.arst_n      (arst_n),
		.default_sel (default_sel),
		.hready      (hready_ret),
		.hreadyout   (ds_hreadyout),
		.hresp       (ds_hresp)
	);

	// error responder never returns data
	assign ds_resp.hreadyout = ds_hreadyout;
	assign ds_resp.hresp     = ds_hresp;
	assign ds_resp.hrdata    = '0;

	// ======================================================================
	// response mux and returned ready
	// ======================================================================

	// data phase owner picks the response, wait states pass straight through
	assign master_out = resp_sel ? ds_resp : slave_in;

	// whatever the master sees is also the bus-wide ready
	assign hready_ret = master_out.hreadyout;

	// address phase forwarded as is
	// master's own hready copy is replaced by the returned ready
	always_comb begin
		slave_out        = master_in;
		slave_out.hready = hready_ret;
	end

	// ======================================================================
	// checks
	// ======================================================================

	// error data phase only follows a phase the slave did not see
	a_no_slave_on_error: assert property (
		@(posedge hclk) disable iff (!arst_n)
		(resp_sel && $past(hready_ret)) |-> !$past(hsel_slave)
	) else $error("error data phase after a selected slave address phase");

endmodule

/* verilog/ahb_default_slave.sv */
// default slave of one path, answers unmapped active transfers with the two-cycle ERROR
`timescale 1ns/1ps

module ahb_default_slave (
	input  logic            hclk,
	input  logic            arst_n,
	// unmapped active transfer in the address phase
	input  logic            default_sel,
	// returned ready of the path
	input  logic            hready,
	output logic            hreadyout,
	output ahb_pkg::hresp_e hresp
);

	import ahb_pkg::*;

	err_state_e state;
	err_state_e state_nxt;
	logic       accept;

	// an unmapped phase counts only once the bus moves on
	assign accept = default_sel && hready;

	// ======================================================================
	// state machine
	// ======================================================================

	always_ff @(posedge hclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ERR_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ERR_IDLE: begin
				if (accept) begin
					state_nxt = ERR_FIRST;
				end
			end
			// wait cycle, bus is stalled here
			ERR_FIRST: begin
				state_nxt = ERR_SECOND;
			end
			// last error cycle, may overlap the next address phase
			ERR_SECOND: begin
				if (accept) begin
					state_nxt = ERR_FIRST;
				end else begin
					state_nxt = ERR_IDLE;
				end
			end
			default: begin
				state_nxt = ERR_IDLE;
			end
		endcase
	end

	// ======================================================================
	// response outputs
	// ======================================================================

	// low only in the first error cycle
	assign hreadyout = (state != ERR_FIRST);

	// ERROR held over both cycles of the response
	assign hresp = (state == ERR_IDLE) ? OKAY : ERROR;

	// ======================================================================
	// checks
	// ======================================================================

	// two-cycle response is never cut short
	a_first_then_second: assert property (
		@(posedge hclk) disable iff (!arst_n)
		(state == ERR_FIRST) |=> (state == ERR_SECOND)
	) else $error("default slave left ERR_FIRST without ERR_SECOND");

	// idle responder is transparent
	a_idle_okay: assert property (
		@(posedge hclk) disable iff (!arst_n)
		(state == ERR_IDLE) |-> (hresp == OKAY)
	) else $error("default slave drives ERROR while idle");

endmodule

/* verilog/ahb_addr_decoder.sv */
// per-path address decoder, instantiated by ahb_path to pick the data-phase responder
`timescale 1ns/1ps

module ahb_addr_decoder #(
	// single window of the path's slave
	parameter ahb_pkg::haddr_t region_base = 32'h0000_0000,
	parameter ahb_pkg::haddr_t region_mask = 32'hFFFF_0000
) (
	input  logic             hclk,
	input  logic             arst_n,
	input  ahb_pkg::haddr_t  haddr,
	input  ahb_pkg::htrans_e htrans,
	// returned ready of the path
	input  logic             hready,
	output logic             hsel,
	output logic             default_sel,
	output logic             resp_sel
);

	import ahb_pkg::*;

	logic addr_match;
	logic trans_active;

	// ======================================================================
	// address phase, purely combinational
	// ======================================================================

	// masked compare against the window base
	assign addr_match = (haddr & region_mask) == region_base;

	// only NONSEQ and SEQ carry a real transfer
	assign trans_active = (htrans == NONSEQ) || (htrans == SEQ);

	// slave select follows the window regardless of htrans
	// the slave itself ignores IDLE and BUSY
	assign hsel = addr_match;

	// unmapped active transfer goes to the error responder
	assign default_sel = trans_active && !addr_match;

	// ======================================================================
	// data phase owner
	// ======================================================================

	// updated only when an address phase is accepted
	// held through wait states so the mux stays put
	always_ff @(posedge hclk or negedge arst_n) begin
		if (!arst_n) begin
			resp_sel <= 1'b0;
		end else if (hready) begin
			resp_sel <= default_sel;
		end
	end

	// ======================================================================
	// checks
	// ======================================================================

	// real slave and error responder never both claim a phase
	a_sel_onehot: assert property (
		@(posedge hclk) disable iff (!arst_n)
		!(hsel && default_sel)
	) else $error("decoder selects slave and default slave together");

endmodule

/* verilog/ahb_pkg.sv */
// shared AHB-Lite types and bundle structs, imported by every interconnect module

package ahb_pkg;

	// ======================================================================
	// plain vector widths
	// ======================================================================

	// byte address, full 32-bit space
	typedef logic [31:0] haddr_t;

	// read and write data words
	typedef logic [31:0] hdata_t;

	// transfer size, byte to word
	typedef logic [2:0] hsize_t;

	// burst type, passed through untouched
	typedef logic [2:0] hburst_t;

	// protection bits, passed through untouched
	typedef logic [3:0] hprot_t;

	// ======================================================================
	// bus encodings
	// ======================================================================

	// htrans codes as in the AHB-Lite spec
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// AHB-Lite has no retry or split, one bit is enough
	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// default slave sequencing for the two-cycle error
	typedef enum logic [1:0] {
		ERR_IDLE   = 2'b00,
		ERR_FIRST  = 2'b01,
		ERR_SECOND = 2'b10
	} err_state_e;

	// ======================================================================
	// bundles
	// ======================================================================

	// master to slave direction, 78 bits
	// hready carries the path's returned ready on the slave side
	typedef struct packed {
		haddr_t  haddr;
		htrans_e htrans;
		logic    hwrite;
		hsize_t  hsize;
		hburst_t hburst;
		hprot_t  hprot;
		hdata_t  hwdata;
		logic    hready;
	} mas_send_t;

	// slave to master direction, 34 bits
	typedef struct packed {
		logic   hreadyout;
		hdata_t hrdata;
		hresp_e hresp;
	} slv_send_t;

endpackage
